// ==== common/fifo_config.svh ====
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// word width of the data path.
`define FIFO_DATA_WIDTH 8

// address width sets the depth, so depth stays a power of two.
`define FIFO_ADDR_WIDTH 4
`define FIFO_DEPTH      (1 << `FIFO_ADDR_WIDTH)

// flag thresholds in words.
`define FIFO_AFULL  14
`define FIFO_AEMPTY 2

`endif

// ==== common/fifo_pkg.sv ====
package fifo_pkg;

  `include "fifo_config.svh"

  typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;
  typedef logic [`FIFO_ADDR_WIDTH-1:0] addr_t;
  // extra msb is the wrap bit.
  typedef logic [`FIFO_ADDR_WIDTH:0]   ptr_t;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin = gray;
    for (int i = `FIFO_ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== hw/dualport_ram.sv ====
`timescale 1ns/1ps

`include "fifo_config.svh"

module dualport_ram (
  input  logic            wr_clk,
  input  logic            wr_en,
  input  fifo_pkg::addr_t wr_addr,
  input  fifo_pkg::data_t wr_data,
  input  logic            rd_clk,
  input  logic            rd_rst_n,
  input  logic            rd_en,
  input  fifo_pkg::addr_t rd_addr,
  output fifo_pkg::data_t rd_data
);

  fifo_pkg::data_t mem [0:`FIFO_DEPTH-1];

  // write port, wr_clk domain.
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read port, holds its value when not reading.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== async_fifo/gray_sync.sv ====
`timescale 1ns/1ps

module gray_sync (
  input  logic           clk,
  input  logic           rst_n,
  input  fifo_pkg::ptr_t gray_in,
  output fifo_pkg::ptr_t gray_out
);

  // first stage may go metastable.
  fifo_pkg::ptr_t meta;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta     <= '0;
      gray_out <= '0;
    end else begin
      meta     <= gray_in;
      gray_out <= meta;
    end
  end

endmodule

// ==== async_fifo/wr_ptr_full.sv ====
`timescale 1ns/1ps

`include "fifo_config.svh"

module wr_ptr_full (
  input  logic            wr_clk,
  input  logic            wr_rst_n,
  input  logic            wr_en,
  input  fifo_pkg::ptr_t  rd_gray_sync,
  output logic            wr_vld,
  output fifo_pkg::addr_t wr_addr,
  output fifo_pkg::ptr_t  wr_gray,
  output logic            full,
  output logic            afull
);

  fifo_pkg::ptr_t wr_bin;
  fifo_pkg::ptr_t wr_bin_nxt;
  fifo_pkg::ptr_t wr_gray_nxt;
  fifo_pkg::ptr_t rd_bin_sync;
  fifo_pkg::ptr_t fill;
  fifo_pkg::ptr_t full_match;

  // writes while full are dropped.
  assign wr_vld = wr_en && !full;

  assign wr_bin_nxt  = wr_bin + fifo_pkg::ptr_t'(wr_vld);
  assign wr_gray_nxt = fifo_pkg::bin2gray(wr_bin_nxt);
  assign wr_addr     = wr_bin[`FIFO_ADDR_WIDTH-1:0];

  // read pointer one lap behind, seen in gray.
  assign full_match = {~rd_gray_sync[`FIFO_ADDR_WIDTH:`FIFO_ADDR_WIDTH-1],
                       rd_gray_sync[`FIFO_ADDR_WIDTH-2:0]};

  assign rd_bin_sync = fifo_pkg::gray2bin(rd_gray_sync);
  assign fill        = wr_bin_nxt - rd_bin_sync;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;
    end
  end

  // flags look at the next pointer so they settle with the write.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (wr_gray_nxt == full_match);
      afull <= (fill >= `FIFO_AFULL);
    end
  end

  assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    full |=> $stable(wr_bin));

  assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $onehot0(wr_gray ^ $past(wr_gray)));

  // full is pessimistic, the synced count never exceeds the depth.
  assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    fill <= `FIFO_DEPTH);

endmodule

// ==== async_fifo/rd_ptr_empty.sv ====
`timescale 1ns/1ps

`include "fifo_config.svh"

module rd_ptr_empty (
  input  logic            rd_clk,
  input  logic            rd_rst_n,
  input  logic            rd_en,
  input  fifo_pkg::ptr_t  wr_gray_sync,
  output logic            rd_vld,
  output fifo_pkg::addr_t rd_addr,
  output fifo_pkg::ptr_t  rd_gray,
  output logic            empty,
  output logic            aempty
);

  fifo_pkg::ptr_t rd_bin;
  fifo_pkg::ptr_t rd_bin_nxt;
  fifo_pkg::ptr_t rd_gray_nxt;
  fifo_pkg::ptr_t wr_bin_sync;
  fifo_pkg::ptr_t fill;

  // reads while empty pop nothing.
  assign rd_vld = rd_en && !empty;

  assign rd_bin_nxt  = rd_bin + fifo_pkg::ptr_t'(rd_vld);
  assign rd_gray_nxt = fifo_pkg::bin2gray(rd_bin_nxt);
  assign rd_addr     = rd_bin[`FIFO_ADDR_WIDTH-1:0];

  assign wr_bin_sync = fifo_pkg::gray2bin(wr_gray_sync);
  assign fill        = wr_bin_sync - rd_bin_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
    end
  end

  // empty after reset.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= (rd_gray_nxt == wr_gray_sync);
      aempty <= (fill <= `FIFO_AEMPTY);
    end
  end

  assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    empty |=> $stable(rd_bin));

  assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    $onehot0(rd_gray ^ $past(rd_gray)));

  // read pointer never passes the synced write pointer.
  assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    fill <= `FIFO_DEPTH);

endmodule

// ==== async_fifo/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo (
  input  logic            wr_clk,
  input  logic            wr_rst_n,
  input  logic            wr_en,
  input  fifo_pkg::data_t wr_data,
  input  logic            rd_clk,
  input  logic            rd_rst_n,
  input  logic            rd_en,
  output fifo_pkg::data_t rd_data,
  output logic            full,
  output logic            empty,
  output logic            afull,
  output logic            aempty
);

  logic            wr_vld;
  logic            rd_vld;
  fifo_pkg::addr_t wr_addr;
  fifo_pkg::addr_t rd_addr;
  fifo_pkg::ptr_t  wr_gray;
  fifo_pkg::ptr_t  rd_gray;
  fifo_pkg::ptr_t  wr_gray_sync;
  fifo_pkg::ptr_t  rd_gray_sync;

  wr_ptr_full u_wr_ptr_full (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .wr_en        (wr_en),
    .rd_gray_sync (rd_gray_sync),
    .wr_vld       (wr_vld),
    .wr_addr      (wr_addr),
    .wr_gray      (wr_gray),
    .full         (full),
    .afull        (afull)
  );

  rd_ptr_empty u_rd_ptr_empty (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_en        (rd_en),
    .wr_gray_sync (wr_gray_sync),
    .rd_vld       (rd_vld),
    .rd_addr      (rd_addr),
    .rd_gray      (rd_gray),
    .empty        (empty),
    .aempty       (aempty)
  );

  // write pointer into the read domain.
  gray_sync u_wr2rd (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n),
    .gray_in  (wr_gray),
    .gray_out (wr_gray_sync)
  );

  // read pointer into the write domain.
  gray_sync u_rd2wr (
    .clk      (wr_clk),
    .rst_n    (wr_rst_n),
    .gray_in  (rd_gray),
    .gray_out (rd_gray_sync)
  );

  dualport_ram u_dualport_ram (
    .wr_clk   (wr_clk),
    .wr_en    (wr_vld),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_vld),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

// ==== bench/tb_async_fifo.sv ====
`timescale 1ns/1ps

`include "fifo_config.svh"

module tb_async_fifo;

  localparam realtime rd_period    = 20.0;
  localparam realtime wr_period    = 14.0;
  localparam int      stream_words = 200;
  localparam int      total_words  = 10 + (`FIFO_DEPTH + 4) + 1 + `FIFO_DEPTH + stream_words;

  logic            wr_clk;
  logic            wr_rst_n;
  logic            wr_en;
  fifo_pkg::data_t wr_data;
  logic            rd_clk;
  logic            rd_rst_n;
  logic            rd_en;
  fifo_pkg::data_t rd_data;
  logic            full;
  logic            empty;
  logic            afull;
  logic            aempty;

  fifo_pkg::data_t model_q [$];
  fifo_pkg::data_t chk_word;
  logic            chk_pending = 1'b0;
  integer          seed;
  int              n_pass = 0;
  int              n_fail = 0;
  int              wr_acc = 0;
  int              rd_acc = 0;

  async_fifo DUT (.*);

  initial begin
    rd_clk = 1'b0;
    forever #(rd_period / 2) rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #(wr_period / 2) wr_clk = ~wr_clk;
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected) begin
      n_pass++;
    end else begin
      $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      n_fail++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond === 1'b1) begin
      n_pass++;
    end else begin
      $display("Error at %0t ns: %s", $time, what);
      n_fail++;
    end
  endtask

  task automatic report_test(input string name, input int fails_before);
    $display("test %s finished with %0d errors", name, n_fail - fails_before);
  endtask

  // model side, write edges and read edges never coincide.
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      model_q.push_back(wr_data);
      wr_acc++;
    end
  end

  // rd_data of an accepted read is checked on the next edge.
  always @(posedge rd_clk) begin
    if (chk_pending) begin
      compare_value("rd_data", chk_word, rd_data);
      chk_pending = 1'b0;
    end
    if (rd_rst_n && rd_en && !empty) begin
      expect_true(model_q.size() > 0, "read accepted while the model held no word");
      if (model_q.size() > 0) begin
        chk_word    = model_q.pop_front();
        chk_pending = 1'b1;
      end
      rd_acc++;
    end
  end

  task automatic write_words(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge wr_clk);
      #2;
      wr_en   = 1'b1;
      wr_data = $random(seed);
    end
    @(posedge wr_clk);
    #2;
    wr_en = 1'b0;
  endtask

  task automatic wait_not_empty();
    int cycles;
    cycles = 0;
    while (empty && cycles < 20) begin
      @(posedge rd_clk);
      #2;
      cycles++;
    end
    expect_true(!empty, "empty did not fall after a write");
  endtask

  task automatic wait_drained(input int max_cycles);
    int cycles;
    cycles = 0;
    while (model_q.size() > 0 && cycles < max_cycles) begin
      @(posedge rd_clk);
      #2;
      cycles++;
    end
    expect_true(model_q.size() == 0, "words still missing after the read timeout");
  endtask

  task automatic drain_all();
    @(posedge rd_clk);
    #2;
    wait_not_empty();
    rd_en = 1'b1;
    wait_drained(4 * `FIFO_DEPTH);
    rd_en = 1'b0;
    repeat (2) @(posedge rd_clk);
    #2;
  endtask

  task automatic reset_state();
    int fails_before;
    fails_before = n_fail;
    compare_value("empty", 1, empty);
    compare_value("aempty", 1, aempty);
    compare_value("full", 0, full);
    compare_value("afull", 0, afull);
    compare_value("rd_data", 0, rd_data);
    report_test("reset_state", fails_before);
  endtask

  task automatic ordered_transfer();
    int fails_before;
    int rd_start;
    fails_before = n_fail;
    rd_start     = rd_acc;
    write_words(10);
    drain_all();
    compare_value("words read", 10, rd_acc - rd_start);
    report_test("ordered_transfer", fails_before);
  endtask

  task automatic fill_to_full();
    int fails_before;
    int wr_start;
    int rd_start;
    fails_before = n_fail;
    // read pointer settles on the write side.
    repeat (6) @(posedge wr_clk);
    wr_start = wr_acc;
    rd_start = rd_acc;
    write_words(`FIFO_DEPTH + 4);
    compare_value("words accepted", `FIFO_DEPTH, wr_acc - wr_start);
    compare_value("full", 1, full);
    drain_all();
    compare_value("words read", `FIFO_DEPTH, rd_acc - rd_start);
    compare_value("empty", 1, empty);
    report_test("fill_to_full", fails_before);
  endtask

  task automatic read_while_empty();
    int              fails_before;
    int              rd_start;
    fifo_pkg::data_t held;
    fifo_pkg::data_t word;
    fails_before = n_fail;
    repeat (6) @(posedge rd_clk);
    #2;
    held     = rd_data;
    rd_start = rd_acc;
    rd_en    = 1'b1;
    repeat (8) @(posedge rd_clk);
    #2;
    compare_value("words read", 0, rd_acc - rd_start);
    compare_value("rd_data", held, rd_data);
    write_words(1);
    word = wr_data;
    wait_drained(20);
    compare_value("rd_data", word, rd_data);
    compare_value("words read", 1, rd_acc - rd_start);
    rd_en = 1'b0;
    repeat (2) @(posedge rd_clk);
    #2;
    report_test("read_while_empty", fails_before);
  endtask

  task automatic threshold_flags();
    int fails_before;
    fails_before = n_fail;
    for (int k = 0; k <= `FIFO_DEPTH; k++) begin
      if (k > 0) begin
        write_words(1);
      end
      repeat (6) @(posedge wr_clk);
      repeat (6) @(posedge rd_clk);
      #2;
      compare_value("afull", model_q.size() >= `FIFO_AFULL, afull);
      compare_value("aempty", model_q.size() <= `FIFO_AEMPTY, aempty);
    end
    drain_all();
    report_test("threshold_flags", fails_before);
  endtask

  task automatic concurrent_stream();
    int fails_before;
    int wr_start;
    int rd_start;
    fails_before = n_fail;
    wr_start     = wr_acc;
    rd_start     = rd_acc;
    fork
      begin
        @(posedge wr_clk);
        #2;
        while (wr_acc - wr_start < stream_words) begin
          wr_en   = ($random(seed) & 1) == 1;
          wr_data = $random(seed);
          @(posedge wr_clk);
          #2;
        end
        wr_en = 1'b0;
      end
      begin
        @(posedge rd_clk);
        #2;
        while (rd_acc - rd_start < stream_words) begin
          rd_en = ($random(seed) & 3) != 0;
          @(posedge rd_clk);
          #2;
        end
        rd_en = 1'b0;
      end
    join
    repeat (2) @(posedge rd_clk);
    #2;
    compare_value("empty", 1, empty);
    compare_value("model size", 0, model_q.size());
    report_test("concurrent_stream", fails_before);
  endtask

  // watchdog.
  initial begin
    #(total_words * 4 * rd_period + 2000.0);
    $display("run timed out before all tests finished");
    $display("Something failed");
    $finish;
  end

  initial begin
    seed     = 32'h1aec;
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    repeat (16) @(posedge rd_clk);
    #2;
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;
    reset_state();
    ordered_transfer();
    fill_to_full();
    read_while_empty();
    threshold_flags();
    concurrent_stream();
    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== async_fifo.f ====
+incdir+common
common/fifo_pkg.sv
hw/dualport_ram.sv
async_fifo/gray_sync.sv
async_fifo/wr_ptr_full.sv
async_fifo/rd_ptr_empty.sv
async_fifo/async_fifo.sv
bench/tb_async_fifo.sv

// ==== Bender.yml ====
package:
  name: async_fifo

sources:
  - include_dirs:
      - common
    files:
      - common/fifo_pkg.sv
      - hw/dualport_ram.sv
      - async_fifo/gray_sync.sv
      - async_fifo/wr_ptr_full.sv
      - async_fifo/rd_ptr_empty.sv
      - async_fifo/async_fifo.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_async_fifo.sv
